// File: Bender.yml
package:
  name: board_io

dependencies: {}

sources:
  # Packages come before the modules that import them
  - source/board_pins_pkg.sv
  - source/board_timing_pkg.sv
  - source/pin_sync.sv
  - source/reset_stretch.sv
  - source/cage_ctrl.sv
  - source/i2c_pad_ctrl.sv
  - source/board_io.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/board_io_checker.sv
      - tb/board_io_tb.sv

// File: board_io.f
source/board_pins_pkg.sv
source/board_timing_pkg.sv
source/pin_sync.sv
source/reset_stretch.sv
source/cage_ctrl.sv
source/i2c_pad_ctrl.sv
source/board_io.sv
tb/tb_clock_gen.sv
tb/board_io_checker.sv
tb/board_io_tb.sv

// File: source/board_io.sv
// Board pin glue top level joining pin sync, reset stretch, cage control and I2C pads
`timescale 1ns/10ps

module board_io (
    input  logic                                  pcie_clk,
    input  logic                                  reset_i,
    input  logic                                  host_rst_i,
    input  logic [board_pins_pkg::PIN_COUNT-1:0]  pins_async_i,
    input  logic                                  fpga_scl_o_i,
    input  logic                                  fpga_scl_t_i,
    input  logic                                  fpga_sda_o_i,
    input  logic                                  fpga_sda_t_i,
    input  logic                                  qsfp_scl_o_i,
    input  logic                                  qsfp_scl_t_i,
    input  logic                                  qsfp_sda_o_i,
    input  logic                                  qsfp_sda_t_i,
    output logic [3:0]                            i2c_in_o,
    output logic                                  board_rst_o,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_reset_l_o,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_lpmode_o,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_irq_o,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_ready_o,
    output logic                                  fpga_scl_pull_o,
    output logic                                  fpga_sda_pull_o,
    output logic                                  qsfp_scl_pull_o,
    output logic                                  qsfp_sda_pull_o
);

    import board_pins_pkg::*;

    pin_word_t pins_sync;
    logic      board_rst;

    pin_sync u_pin_sync (
        .pcie_clk     (pcie_clk),
        .reset_i      (reset_i),
        .pins_async_i (pins_async_i),
        .pins_sync_o  (pins_sync)
    );

    reset_stretch u_reset_stretch (
        .pcie_clk    (pcie_clk),
        .reset_i     (reset_i),
        .host_rst_i  (host_rst_i),
        .board_rst_o (board_rst)
    );

    cage_ctrl u_cage_ctrl (
        .pcie_clk       (pcie_clk),
        .reset_i        (reset_i),
        .pins_sync_i    (pins_sync),
        .board_rst_i    (board_rst),
        .cage_reset_l_o (cage_reset_l_o),
        .cage_lpmode_o  (cage_lpmode_o),
        .cage_irq_o     (cage_irq_o),
        .cage_ready_o   (cage_ready_o)
    );

    i2c_pad_ctrl u_i2c_pad_ctrl (
        .pcie_clk        (pcie_clk),
        .reset_i         (reset_i),
        .fpga_scl_o_i    (fpga_scl_o_i),
        .fpga_scl_t_i    (fpga_scl_t_i),
        .fpga_sda_o_i    (fpga_sda_o_i),
        .fpga_sda_t_i    (fpga_sda_t_i),
        .qsfp_scl_o_i    (qsfp_scl_o_i),
        .qsfp_scl_t_i    (qsfp_scl_t_i),
        .qsfp_sda_o_i    (qsfp_sda_o_i),
        .qsfp_sda_t_i    (qsfp_sda_t_i),
        .fpga_scl_pull_o (fpga_scl_pull_o),
        .fpga_sda_pull_o (fpga_sda_pull_o),
        .qsfp_scl_pull_o (qsfp_scl_pull_o),
        .qsfp_sda_pull_o (qsfp_sda_pull_o)
    );

    // Synchronised I2C line levels back to the core, in pin word order
    assign i2c_in_o = {pins_sync.fields.qsfp_scl, pins_sync.fields.qsfp_sda,
                       pins_sync.fields.fpga_scl, pins_sync.fields.fpga_sda};

    assign board_rst_o = board_rst;

endmodule

// File: source/board_pins_pkg.sv
// Board pin definitions for the QSFP-DD cages and the I2C input pins
package board_pins_pkg;

    // QSFP-DD cages on the board
    localparam int CAGE_COUNT = 2;

    // Asynchronous board inputs sampled into the pcie_clk domain
    localparam int PIN_COUNT = 8;

    // Pin order, most significant bit first
    // Status pins are active low and pulled up on the board
    typedef struct packed {
        logic cage0_int_l;
        logic cage0_modprs_l;
        logic cage1_int_l;
        logic cage1_modprs_l;
        logic qsfp_scl;
        logic qsfp_sda;
        logic fpga_scl;
        logic fpga_sda;
    } pin_fields_t;

    // One pin word, read raw by the synchroniser and by name downstream
    typedef union packed {
        logic [PIN_COUNT-1:0] flat;
        pin_fields_t          fields;
    } pin_word_t;

endpackage

// File: source/board_timing_pkg.sv
// Board timing constants for pin synchronisation and reset stretching
package board_timing_pkg;

    // Flip-flop stages between a board pin and its first use
    localparam int SYNC_STAGES = 2;

    // Cycles the board reset is held once the core reset is gone
    localparam int RESET_HOLD_CYCLES = 20;

    // Stretch counter width, must hold RESET_HOLD_CYCLES
    localparam int RESET_CNT_WIDTH = 5;

endpackage

// File: source/cage_ctrl.sv
// QSFP-DD cage control for module reset, low-power mode, interrupt and ready
`timescale 1ns/10ps

module cage_ctrl (
    input  logic                                  pcie_clk,
    input  logic                                  reset_i,
    input  board_pins_pkg::pin_word_t             pins_sync_i,
    input  logic                                  board_rst_i,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_reset_l_o,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_lpmode_o,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_irq_o,
    output logic [board_pins_pkg::CAGE_COUNT-1:0] cage_ready_o
);

    import board_pins_pkg::*;

    logic [CAGE_COUNT-1:0] modprs_l;
    logic [CAGE_COUNT-1:0] int_l;
    logic [CAGE_COUNT-1:0] int_l_q;
    logic [CAGE_COUNT-1:0] present;
    logic [CAGE_COUNT-1:0] active;
    logic [CAGE_COUNT-1:0] int_fall;

    // Bit 0 is cage 0
    assign modprs_l = {pins_sync_i.fields.cage1_modprs_l,
                       pins_sync_i.fields.cage0_modprs_l};
    assign int_l    = {pins_sync_i.fields.cage1_int_l,
                       pins_sync_i.fields.cage0_int_l};

    assign present  = ~modprs_l;
    // Module plugged in and board out of reset
    assign active   = present & {CAGE_COUNT{~board_rst_i}};
    assign int_fall = int_l_q & ~int_l;

    always_ff @(posedge pcie_clk) begin
        if (reset_i) begin
            int_l_q        <= '1;
            cage_reset_l_o <= '0;
            cage_lpmode_o  <= '1;
            cage_irq_o     <= '0;
            cage_ready_o   <= '0;
        end else begin
            int_l_q        <= int_l;
            cage_reset_l_o <= active;
            // Empty cage stays in low-power mode
            cage_lpmode_o  <= modprs_l;
            cage_irq_o     <= int_fall & active;
            // Ready one cycle behind the released module reset
            cage_ready_o   <= cage_reset_l_o;
        end
    end

endmodule

// File: source/i2c_pad_ctrl.sv
// Registered open-drain drive for the board and cage I2C buses
`timescale 1ns/10ps

module i2c_pad_ctrl (
    input  logic pcie_clk,
    input  logic reset_i,
    input  logic fpga_scl_o_i,
    input  logic fpga_scl_t_i,
    input  logic fpga_sda_o_i,
    input  logic fpga_sda_t_i,
    input  logic qsfp_scl_o_i,
    input  logic qsfp_scl_t_i,
    input  logic qsfp_sda_o_i,
    input  logic qsfp_sda_t_i,
    output logic fpga_scl_pull_o,
    output logic fpga_sda_pull_o,
    output logic qsfp_scl_pull_o,
    output logic qsfp_sda_pull_o
);

    // Lines packed as qsfp scl, qsfp sda, fpga scl, fpga sda
    logic [3:0] line_o_q;
    logic [3:0] line_t_q;
    logic [3:0] pull;

    // Pads start released
    always_ff @(posedge pcie_clk) begin
        if (reset_i) begin
            line_t_q <= '1;
        end else begin
            line_t_q <= {qsfp_scl_t_i, qsfp_sda_t_i, fpga_scl_t_i, fpga_sda_t_i};
        end
    end

    always_ff @(posedge pcie_clk) begin
        line_o_q <= {qsfp_scl_o_i, qsfp_sda_o_i, fpga_scl_o_i, fpga_sda_o_i};
    end

    // Pull low only when driven and driving zero, else the pull-up wins
    assign pull = ~line_t_q & ~line_o_q;

    assign qsfp_scl_pull_o = pull[3];
    assign qsfp_sda_pull_o = pull[2];
    assign fpga_scl_pull_o = pull[1];
    assign fpga_sda_pull_o = pull[0];

endmodule

// File: source/pin_sync.sv
// Two-stage synchroniser for the board status and I2C input pins
`timescale 1ns/10ps

module pin_sync (
    input  logic                                 pcie_clk,
    input  logic                                 reset_i,
    input  logic [board_pins_pkg::PIN_COUNT-1:0] pins_async_i,
    output board_pins_pkg::pin_word_t            pins_sync_o
);

    import board_pins_pkg::*;
    import board_timing_pkg::*;

    // Stage 0 samples the pads, last stage feeds the consumers
    pin_word_t sync_q [SYNC_STAGES];

    always_ff @(posedge pcie_clk) begin
        if (reset_i) begin
            // All ones is the idle level of the pulled-up pins
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i].flat <= '1;
            end
        end else begin
            sync_q[0].flat <= pins_async_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign pins_sync_o = sync_q[SYNC_STAGES-1];

endmodule

// File: source/reset_stretch.sv
// Board reset stretcher that holds reset for a settle time after core reset
`timescale 1ns/10ps

module reset_stretch (
    input  logic pcie_clk,
    input  logic reset_i,
    input  logic host_rst_i,
    output logic board_rst_o
);

    import board_timing_pkg::*;

    logic [RESET_CNT_WIDTH-1:0] hold_cnt_q;

    // Either reset reloads the full hold time
    // Count runs down to zero once both resets are low
    always_ff @(posedge pcie_clk) begin
        if (reset_i || host_rst_i) begin
            hold_cnt_q <= RESET_CNT_WIDTH'(RESET_HOLD_CYCLES);
        end else if (hold_cnt_q != '0) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
        end
    end

    // Cages stay in reset until the count runs out
    assign board_rst_o = (hold_cnt_q != '0);

endmodule

// File: tb/board_io_checker.sv
// Cycle-exact reference model and output comparison for the board pin glue
`timescale 1ns/10ps

module board_io_checker (
    input  logic                                  pcie_clk,
    input  logic                                  reset_i,
    input  logic                                  host_rst_i,
    input  logic [board_pins_pkg::PIN_COUNT-1:0]  pins_async_i,
    input  logic                                  fpga_scl_o_i,
    input  logic                                  fpga_scl_t_i,
    input  logic                                  fpga_sda_o_i,
    input  logic                                  fpga_sda_t_i,
    input  logic                                  qsfp_scl_o_i,
    input  logic                                  qsfp_scl_t_i,
    input  logic                                  qsfp_sda_o_i,
    input  logic                                  qsfp_sda_t_i,
    input  logic [3:0]                            i2c_in_i,
    input  logic                                  board_rst_i,
    input  logic [board_pins_pkg::CAGE_COUNT-1:0] cage_reset_l_i,
    input  logic [board_pins_pkg::CAGE_COUNT-1:0] cage_lpmode_i,
    input  logic [board_pins_pkg::CAGE_COUNT-1:0] cage_irq_i,
    input  logic [board_pins_pkg::CAGE_COUNT-1:0] cage_ready_i,
    input  logic                                  fpga_scl_pull_i,
    input  logic                                  fpga_sda_pull_i,
    input  logic                                  qsfp_scl_pull_i,
    input  logic                                  qsfp_sda_pull_i,
    output int                                    mismatch_count_o,
    output int                                    other_error_count_o,
    output int                                    checked_cycles_o
);

    import board_pins_pkg::*;
    import board_timing_pkg::*;

    // Model registers, state after the last rising edge
    pin_word_t             sync_m [SYNC_STAGES];
    int                    hold_cnt_m;
    logic [CAGE_COUNT-1:0] int_l_m;
    logic [CAGE_COUNT-1:0] reset_l_m;
    logic [CAGE_COUNT-1:0] lpmode_m;
    logic [CAGE_COUNT-1:0] irq_m;
    logic [CAGE_COUNT-1:0] ready_m;
    // Line order qsfp scl, qsfp sda, fpga scl, fpga sda
    logic [3:0]            t_m;
    logic [3:0]            o_m;

    // Inputs of the cycle that the last edge sampled
    logic                  prev_reset;
    logic                  prev_host;
    logic [PIN_COUNT-1:0]  prev_pins;
    logic [3:0]            prev_t;
    logic [3:0]            prev_o;
    logic                  have_prev   = 1'b0;
    logic                  model_valid = 1'b0;
    logic [CAGE_COUNT-1:0] irq_seen_q  = '0;

    int mismatch_count    = 0;
    int other_error_count = 0;
    int checked_cycles    = 0;

    assign mismatch_count_o    = mismatch_count;
    assign other_error_count_o = other_error_count;
    assign checked_cycles_o    = checked_cycles;

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s expected 0x%h actual 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // One rising edge of the reference model
    task automatic advance_model();
        pin_word_t             last;
        logic [CAGE_COUNT-1:0] modprs_l;
        logic [CAGE_COUNT-1:0] int_l;
        logic [CAGE_COUNT-1:0] enabled;
        last     = sync_m[SYNC_STAGES-1];
        modprs_l = {last.fields.cage1_modprs_l, last.fields.cage0_modprs_l};
        int_l    = {last.fields.cage1_int_l, last.fields.cage0_int_l};
        // Present and not held in board reset
        enabled  = ~modprs_l & {CAGE_COUNT{hold_cnt_m == 0}};
        if (prev_reset) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_m[i].flat = '1;
            end
            int_l_m     = '1;
            reset_l_m   = '0;
            lpmode_m    = '1;
            irq_m       = '0;
            ready_m     = '0;
            t_m         = 4'hf;
            model_valid = 1'b1;
        end else begin
            ready_m   = reset_l_m;
            reset_l_m = enabled;
            lpmode_m  = modprs_l;
            irq_m     = int_l_m & ~int_l & enabled;
            int_l_m   = int_l;
            t_m       = prev_t;
            for (int i = SYNC_STAGES - 1; i > 0; i--) begin
                sync_m[i] = sync_m[i-1];
            end
            sync_m[0].flat = prev_pins;
        end
        o_m = prev_o;
        if (prev_reset || prev_host) begin
            hold_cnt_m = RESET_HOLD_CYCLES;
        end else if (hold_cnt_m != 0) begin
            hold_cnt_m--;
        end
    endtask

    task automatic compare_outputs();
        pin_word_t  last;
        logic [3:0] pull_m;
        last   = sync_m[SYNC_STAGES-1];
        pull_m = ~t_m & ~o_m;
        check_value("i2c_in_o", {last.fields.qsfp_scl, last.fields.qsfp_sda,
                                 last.fields.fpga_scl, last.fields.fpga_sda}, i2c_in_i);
        check_value("board_rst_o", hold_cnt_m != 0, board_rst_i);
        check_value("cage_reset_l_o", reset_l_m, cage_reset_l_i);
        check_value("cage_lpmode_o", lpmode_m, cage_lpmode_i);
        check_value("cage_irq_o", irq_m, cage_irq_i);
        check_value("cage_ready_o", ready_m, cage_ready_i);
        check_value("qsfp_scl_pull_o", pull_m[3], qsfp_scl_pull_i);
        check_value("qsfp_sda_pull_o", pull_m[2], qsfp_sda_pull_i);
        check_value("fpga_scl_pull_o", pull_m[1], fpga_scl_pull_i);
        check_value("fpga_sda_pull_o", pull_m[0], fpga_sda_pull_i);
        if ((cage_irq_i & irq_seen_q) != '0) begin
            other_error_count++;
            $display("cage_irq_o stayed high for more than one cycle at %0t", $time);
        end
        irq_seen_q = cage_irq_i;
        checked_cycles++;
    endtask

    // Values straight out of reset
    task automatic check_reset_values();
        check_value("board_rst_o", 8'h01, board_rst_i);
        check_value("cage_reset_l_o", 8'h00, cage_reset_l_i);
        check_value("cage_lpmode_o", 8'h03, cage_lpmode_i);
        check_value("cage_irq_o", 8'h00, cage_irq_i);
        check_value("cage_ready_o", 8'h00, cage_ready_i);
        check_value("pull outputs", 8'h00, {qsfp_scl_pull_i, qsfp_sda_pull_i,
                                           fpga_scl_pull_i, fpga_sda_pull_i});
    endtask

    // Inputs and outputs are both settled at the falling edge
    always @(negedge pcie_clk) begin
        if (have_prev) begin
            advance_model();
        end
        if (model_valid) begin
            compare_outputs();
            if (prev_reset && !reset_i) begin
                check_reset_values();
            end
        end
        prev_reset = reset_i;
        prev_host  = host_rst_i;
        prev_pins  = pins_async_i;
        prev_t     = {qsfp_scl_t_i, qsfp_sda_t_i, fpga_scl_t_i, fpga_sda_t_i};
        prev_o     = {qsfp_scl_o_i, qsfp_sda_o_i, fpga_scl_o_i, fpga_sda_o_i};
        have_prev  = 1'b1;
    end

endmodule

// File: tb/board_io_tb.sv
// Test top for the board pin glue with seeded random pin and I2C stimulus
`timescale 1ns/10ps

module board_io_tb;

    import board_pins_pkg::*;
    import board_timing_pkg::*;

    localparam int RANDOM_CYCLES   = 3000;
    localparam int RELEASE_TIMEOUT = 16;
    localparam int FALL_TIMEOUT    = RESET_HOLD_CYCLES + 8;
    localparam int RESTART_GAP     = 8;

    // Host reset control per stimulus cycle
    localparam int HOST_OFF    = 0;
    localparam int HOST_RANDOM = 1;
    localparam int HOST_PULSE  = 2;

    logic                  pcie_clk;
    logic                  reset;
    logic                  host_rst;
    logic [PIN_COUNT-1:0]  pins_async;
    logic                  fpga_scl_o;
    logic                  fpga_scl_t;
    logic                  fpga_sda_o;
    logic                  fpga_sda_t;
    logic                  qsfp_scl_o;
    logic                  qsfp_scl_t;
    logic                  qsfp_sda_o;
    logic                  qsfp_sda_t;
    logic [3:0]            i2c_in;
    logic                  board_rst;
    logic [CAGE_COUNT-1:0] cage_reset_l;
    logic [CAGE_COUNT-1:0] cage_lpmode;
    logic [CAGE_COUNT-1:0] cage_irq;
    logic [CAGE_COUNT-1:0] cage_ready;
    logic                  fpga_scl_pull;
    logic                  fpga_sda_pull;
    logic                  qsfp_scl_pull;
    logic                  qsfp_sda_pull;

    int     mismatch_count;
    int     other_error_count;
    int     checked_cycles;
    int     timeout_count = 0;
    integer seed;

    tb_clock_gen u_tb_clock_gen (
        .pcie_clk_o (pcie_clk),
        .reset_o    (reset)
    );

    board_io u_board_io (
        .pcie_clk        (pcie_clk),
        .reset_i         (reset),
        .host_rst_i      (host_rst),
        .pins_async_i    (pins_async),
        .fpga_scl_o_i    (fpga_scl_o),
        .fpga_scl_t_i    (fpga_scl_t),
        .fpga_sda_o_i    (fpga_sda_o),
        .fpga_sda_t_i    (fpga_sda_t),
        .qsfp_scl_o_i    (qsfp_scl_o),
        .qsfp_scl_t_i    (qsfp_scl_t),
        .qsfp_sda_o_i    (qsfp_sda_o),
        .qsfp_sda_t_i    (qsfp_sda_t),
        .i2c_in_o        (i2c_in),
        .board_rst_o     (board_rst),
        .cage_reset_l_o  (cage_reset_l),
        .cage_lpmode_o   (cage_lpmode),
        .cage_irq_o      (cage_irq),
        .cage_ready_o    (cage_ready),
        .fpga_scl_pull_o (fpga_scl_pull),
        .fpga_sda_pull_o (fpga_sda_pull),
        .qsfp_scl_pull_o (qsfp_scl_pull),
        .qsfp_sda_pull_o (qsfp_sda_pull)
    );

    board_io_checker u_board_io_checker (
        .pcie_clk            (pcie_clk),
        .reset_i             (reset),
        .host_rst_i          (host_rst),
        .pins_async_i        (pins_async),
        .fpga_scl_o_i        (fpga_scl_o),
        .fpga_scl_t_i        (fpga_scl_t),
        .fpga_sda_o_i        (fpga_sda_o),
        .fpga_sda_t_i        (fpga_sda_t),
        .qsfp_scl_o_i        (qsfp_scl_o),
        .qsfp_scl_t_i        (qsfp_scl_t),
        .qsfp_sda_o_i        (qsfp_sda_o),
        .qsfp_sda_t_i        (qsfp_sda_t),
        .i2c_in_i            (i2c_in),
        .board_rst_i         (board_rst),
        .cage_reset_l_i      (cage_reset_l),
        .cage_lpmode_i       (cage_lpmode),
        .cage_irq_i          (cage_irq),
        .cage_ready_i        (cage_ready),
        .fpga_scl_pull_i     (fpga_scl_pull),
        .fpga_sda_pull_i     (fpga_sda_pull),
        .qsfp_scl_pull_i     (qsfp_scl_pull),
        .qsfp_sda_pull_i     (qsfp_sda_pull),
        .mismatch_count_o    (mismatch_count),
        .other_error_count_o (other_error_count),
        .checked_cycles_o    (checked_cycles)
    );

    // One stimulus cycle driven 1 ns after the rising edge
    task automatic drive_step(input int host_mode);
        logic [31:0] r;
        @(posedge pcie_clk);
        #1;
        r = $random(seed);
        {qsfp_scl_o, qsfp_scl_t, qsfp_sda_o, qsfp_sda_t,
         fpga_scl_o, fpga_scl_t, fpga_sda_o, fpga_sda_t} = r[7:0];
        // Each pin toggles with a chance of 1 in 16
        for (int i = 0; i < PIN_COUNT; i++) begin
            r = $random(seed);
            if (r[3:0] == 4'h0) begin
                pins_async[i] = ~pins_async[i];
            end
        end
        r = $random(seed);
        case (host_mode)
            HOST_PULSE:  host_rst = 1'b1;
            HOST_RANDOM: host_rst = (r[6:0] == 7'h00);
            default:     host_rst = 1'b0;
        endcase
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        // Reset may still be unknown at time zero
        while (reset !== 1'b0 && cycles < RELEASE_TIMEOUT) begin
            @(posedge pcie_clk);
            #2;
            cycles++;
        end
        if (reset !== 1'b0) begin
            timeout_count++;
            $display("timeout: reset_i still high after %0d cycles", cycles);
        end
    endtask

    // Keeps stimulus running without host reset until the board reset ends
    task automatic wait_board_rst_fall();
        int cycles;
        cycles = 0;
        while (board_rst && cycles < FALL_TIMEOUT) begin
            drive_step(HOST_OFF);
            cycles++;
        end
        if (board_rst) begin
            timeout_count++;
            $display("timeout: board_rst_o did not fall within %0d cycles", cycles);
        end
    endtask

    initial begin
        seed       = 32'h25ad;
        host_rst   = 1'b0;
        pins_async = '1;
        fpga_scl_o = 1'b1;
        fpga_scl_t = 1'b1;
        fpga_sda_o = 1'b1;
        fpga_sda_t = 1'b1;
        qsfp_scl_o = 1'b1;
        qsfp_scl_t = 1'b1;
        qsfp_sda_o = 1'b1;
        qsfp_sda_t = 1'b1;

        wait_reset_release();
        if (timeout_count == 0) begin
            wait_board_rst_fall();
        end
        // Second host reset pulse lands in the middle of the count
        if (timeout_count == 0) begin
            drive_step(HOST_PULSE);
            repeat (RESTART_GAP) drive_step(HOST_OFF);
            drive_step(HOST_PULSE);
            wait_board_rst_fall();
        end
        if (timeout_count == 0) begin
            repeat (RANDOM_CYCLES) drive_step(HOST_RANDOM);
            wait_board_rst_fall();
        end
        repeat (4) drive_step(HOST_OFF);

        if (checked_cycles == 0) begin
            $display("no DUT output cycle was checked");
        end
        $display("checked %0d cycles, %0d mismatches, %0d other errors, %0d timeouts",
                 checked_cycles, mismatch_count, other_error_count, timeout_count);
        if (timeout_count == 0 && mismatch_count == 0 && other_error_count == 0 &&
            checked_cycles > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
// Clock and reset source for the board pin glue testbench
`timescale 1ns/10ps

module tb_clock_gen (
    output logic pcie_clk_o,
    output logic reset_o
);

    localparam real HALF_PERIOD_NS = 4.0;
    localparam int  RESET_CYCLES   = 2;

    initial begin
        pcie_clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) pcie_clk_o = ~pcie_clk_o;
    end

    // Reset released just after an edge, like the other stimulus
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge pcie_clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule
